// File: rtl/pov_geom_pkg.sv
package pov_geom_pkg;

    // angle resolution, 256 steps per turn
    localparam int THETA_BITS = 8;

    // top bits of theta pick one of 8 sectors
    localparam int SECTOR_BITS = 3;

    // one angle word
    typedef logic [THETA_BITS-1:0] theta_t;

    // built-in test patterns
    typedef enum logic {
        MODE_SECTOR = 1'b0, // colour wheel, one colour per sector
        MODE_RING   = 1'b1  // white diagonal across the panel
    } pattern_mode_e;

    // one on/off bit per colour, no pwm depth
    typedef struct packed {
        logic r; // colour value bit 2
        logic g; // bit 1
        logic b; // bit 0
    } pixel_t;

    localparam pixel_t PIX_BLACK = '{r: 1'b0, g: 1'b0, b: 1'b0};
    localparam pixel_t PIX_WHITE = '{r: 1'b1, g: 1'b1, b: 1'b1};

endpackage

// File: rtl/hub75_pkg.sv
package hub75_pkg;

    // 16x16 panel, two rows driven per scan address
    localparam int PANEL_COLS = 16;
    localparam int SCAN_ADDRS = 8;
    localparam int ADDR_BITS  = 3;
    localparam int COL_BITS   = $clog2(PANEL_COLS);

    // depth of the line buffer, also the renderer's starting credits
    localparam int LINE_CREDITS = 2;
    localparam int CREDIT_BITS  = $clog2(LINE_CREDITS + 1);

    typedef logic [ADDR_BITS-1:0] scan_addr_t;

    // one rendered line pair, 99 bits
    typedef struct packed {
        scan_addr_t                               addr;  // row address on the panel
        pov_geom_pkg::pixel_t [PANEL_COLS-1:0]    upper; // row addr, index is column
        pov_geom_pkg::pixel_t [PANEL_COLS-1:0]    lower; // row addr + SCAN_ADDRS
    } line_pair_t;

    // panel connector, 12 bits
    typedef struct packed {
        scan_addr_t           addr;
        pov_geom_pkg::pixel_t rgb0;  // upper half data
        pov_geom_pkg::pixel_t rgb1;  // lower half data
        logic                 latch;
        logic                 oe_n;  // low = leds on
        logic                 clk;   // shift clock, data taken on rise
    } hub75_pins_t;

endpackage

// File: rtl/rotation_tracker.sv
module rotation_tracker #(
    parameter int STALL_CYCLES = 65536
) (
    input  wire                   sysclk,
    input  wire                   rst,
    input  wire                   ir_tripped,
    output pov_geom_pkg::theta_t  theta,
    output logic                  locked,
    output logic                  ir_seen
);
    import pov_geom_pkg::*;

    // counter must get past STALL_CYCLES without wrapping
    localparam int CNT_BITS = $clog2(STALL_CYCLES + 2);
    localparam int ACC_BITS = CNT_BITS + 1;
    localparam logic [CNT_BITS-1:0] CNT_MAX   = CNT_BITS'(STALL_CYCLES + 1);
    localparam logic [CNT_BITS-1:0] CNT_STALL = CNT_BITS'(STALL_CYCLES);
    localparam logic [ACC_BITS-1:0] ACC_STEP  = ACC_BITS'(1 << THETA_BITS);

    logic                ir_meta;   // first sync stage
    logic                ir_sync;   // second sync stage
    logic                ir_dly;    // edge register
    logic                rise;
    logic [CNT_BITS-1:0] cnt;       // cycles since last edge, saturates
    logic [CNT_BITS-1:0] period;    // last measured revolution
    logic [ACC_BITS-1:0] acc;       // phase accumulator
    logic [ACC_BITS-1:0] acc_sum;
    logic                seen_edge; // one edge since reset or stall
    logic                stalled;

    assign rise    = ir_sync & ~ir_dly;
    assign acc_sum = acc + ACC_STEP;
    assign stalled = (cnt > CNT_STALL); // gate quiet for too long

    always_ff @(posedge sysclk) begin
        if (rst) begin
            ir_meta <= 1'b0;
            ir_sync <= 1'b0;
            ir_dly  <= 1'b0;
        end else begin
            ir_meta <= ir_tripped;
            ir_sync <= ir_meta;
            ir_dly  <= ir_sync;
        end
    end

    // revolution period, only valid once seen_edge was set
    always_ff @(posedge sysclk) begin
        if (rise) begin
            period <= cnt + 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            cnt       <= '0;
            seen_edge <= 1'b0;
            locked    <= 1'b0;
            ir_seen   <= 1'b0;
        end else if (rise) begin
            cnt       <= '0; // restart measurement
            seen_edge <= 1'b1;
            locked    <= seen_edge; // second edge gives a full period
            ir_seen   <= ~ir_seen;
        end else begin
            if (cnt != CNT_MAX) begin
                cnt <= cnt + 1'b1;
            end
            if (stalled) begin
                locked    <= 1'b0;
                seen_edge <= 1'b0; // next edge starts over
            end
        end
    end

    // spread 256 theta steps over one period
    always_ff @(posedge sysclk) begin
        if (rst || rise) begin
            acc   <= '0;
            theta <= '0;
        end else if (!locked) begin
            acc <= '0;
        end else if (acc_sum >= {1'b0, period}) begin
            acc <= acc_sum - {1'b0, period};
            if (theta != '1) begin
                theta <= theta + 1'b1; // hold at 255 if revolution runs long
            end
        end else begin
            acc <= acc_sum;
        end
    end

endmodule

// File: rtl/line_renderer.sv
module line_renderer (
    input  wire                          sysclk,
    input  wire                          rst,
    input  pov_geom_pkg::theta_t         theta,
    input  wire                          locked,
    input  pov_geom_pkg::pattern_mode_e  mode,
    input  wire                          credit_return,
    output logic                         line_push,
    output hub75_pkg::line_pair_t        line_data
);
    import pov_geom_pkg::*;
    import hub75_pkg::*;

    localparam scan_addr_t LAST_ADDR = ADDR_BITS'(SCAN_ADDRS - 1);

    logic [CREDIT_BITS-1:0]  credits;     // free slots in the output buffer
    logic                    take;        // spend a credit this cycle
    scan_addr_t              scan_addr;   // address of the next line
    logic [SECTOR_BITS-1:0]  sector_base;
    line_pair_t              next_line;

    assign take        = (credits != '0);
    assign sector_base = theta[THETA_BITS-1 -: SECTOR_BITS];

    // pixel rules for the line at scan_addr
    always_comb begin
        next_line.addr = scan_addr;
        for (int c = 0; c < PANEL_COLS; c++) begin
            if (!locked) begin
                next_line.upper[c] = PIX_BLACK; // no valid angle yet
                next_line.lower[c] = PIX_BLACK;
            end else if (mode == MODE_SECTOR) begin
                // colour rotates with the column, both halves alike
                next_line.upper[c] = pixel_t'(sector_base + SECTOR_BITS'(c));
                next_line.lower[c] = pixel_t'(sector_base + SECTOR_BITS'(c));
            end else begin
                // diagonal, row = addr + 8 * half
                next_line.upper[c] = (COL_BITS'(c) == {1'b0, scan_addr}) ?
                                     PIX_WHITE : PIX_BLACK;
                next_line.lower[c] = (COL_BITS'(c) == {1'b1, scan_addr}) ?
                                     PIX_WHITE : PIX_BLACK;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            credits   <= CREDIT_BITS'(LINE_CREDITS); // buffer starts empty
            line_push <= 1'b0;
            scan_addr <= '0;
        end else begin
            line_push <= take;
            case ({take, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits; // both or neither
            endcase
            if (take) begin
                scan_addr <= (scan_addr == LAST_ADDR) ? '0 : scan_addr + 1'b1;
            end
        end
    end

    // line captured with the credit, shows up with line_push
    always_ff @(posedge sysclk) begin
        if (take) begin
            line_data <= next_line;
        end
    end

endmodule

// File: rtl/hub75_output.sv
module hub75_output #(
    parameter int DISPLAY_CYCLES = 16
) (
    input  wire                    sysclk,
    input  wire                    rst,
    input  wire                    line_push,
    input  hub75_pkg::line_pair_t  line_data,
    output logic                   credit_return,
    output hub75_pkg::hub75_pins_t hub75
);
    import pov_geom_pkg::*;
    import hub75_pkg::*;

    localparam int PTR_BITS  = (LINE_CREDITS > 1) ? $clog2(LINE_CREDITS) : 1;
    localparam int DISP_BITS = $clog2(DISPLAY_CYCLES + 1);
    localparam logic [PTR_BITS-1:0]  LAST_PTR  = PTR_BITS'(LINE_CREDITS - 1);
    localparam logic [COL_BITS-1:0]  LAST_COL  = COL_BITS'(PANEL_COLS - 1);
    localparam logic [DISP_BITS-1:0] DISP_LAST = DISP_BITS'(DISPLAY_CYCLES - 1);
    localparam hub75_pins_t PINS_RESET = '{
        addr: '0, rgb0: PIX_BLACK, rgb1: PIX_BLACK, latch: 1'b0, oe_n: 1'b1, clk: 1'b0
    };

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SHIFT,   // two cycles per column
        ST_BLANK,
        ST_LATCH,
        ST_DISPLAY
    } seq_state_e;

    line_pair_t             fifo_mem [LINE_CREDITS];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CREDIT_BITS-1:0] fifo_count; // entries held
    logic                   pop;

    seq_state_e             state, state_next;
    logic [COL_BITS-1:0]    col, col_next;
    logic                   phase, phase_next;  // 0 = clk low half, 1 = high
    logic [DISP_BITS-1:0]   disp_cnt, disp_next;
    line_pair_t             cur_line, line_next;
    hub75_pins_t            pins_d;

    assign pop           = (state == ST_IDLE) && (fifo_count != '0);
    assign credit_return = pop; // slot is free as soon as it is read
    assign line_next     = pop ? fifo_mem[rd_ptr] : cur_line;

    always_ff @(posedge sysclk) begin
        if (line_push) begin
            fifo_mem[wr_ptr] <= line_data;
        end
        if (pop) begin
            cur_line <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (line_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({line_push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // sequencer next state
    always_comb begin
        state_next = state;
        col_next   = col;
        phase_next = phase;
        disp_next  = disp_cnt;
        case (state)
            ST_IDLE: begin
                if (pop) begin
                    state_next = ST_SHIFT;
                    col_next   = '0;
                    phase_next = 1'b0;
                end
            end
            ST_SHIFT: begin
                if (!phase) begin
                    phase_next = 1'b1; // rising clk, data already stable
                end else begin
                    phase_next = 1'b0;
                    if (col == LAST_COL) begin
                        state_next = ST_BLANK;
                    end else begin
                        col_next = col + 1'b1;
                    end
                end
            end
            ST_BLANK: state_next = ST_LATCH;
            ST_LATCH: begin
                state_next = ST_DISPLAY;
                disp_next  = '0;
            end
            ST_DISPLAY: begin
                if (disp_cnt == DISP_LAST) begin
                    state_next = ST_IDLE;
                end else begin
                    disp_next = disp_cnt + 1'b1;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    // pins decoded from next state so they leave a flop
    always_comb begin
        pins_d.clk   = (state_next == ST_SHIFT) && phase_next;
        pins_d.rgb0  = (state_next == ST_SHIFT) ? line_next.upper[col_next] : PIX_BLACK;
        pins_d.rgb1  = (state_next == ST_SHIFT) ? line_next.lower[col_next] : PIX_BLACK;
        pins_d.latch = (state_next == ST_LATCH);
        pins_d.oe_n  = (state_next != ST_DISPLAY); // dark except while displaying
        pins_d.addr  = (state_next == ST_LATCH) ? line_next.addr : hub75.addr;
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state    <= ST_IDLE;
            col      <= '0;
            phase    <= 1'b0;
            disp_cnt <= '0;
            hub75    <= PINS_RESET;
        end else begin
            state    <= state_next;
            col      <= col_next;
            phase    <= phase_next;
            disp_cnt <= disp_next;
            hub75    <= pins_d;
        end
    end

endmodule

// File: rtl/pov_display_top.sv
module pov_display_top #(
    parameter int STALL_CYCLES   = 65536, // quiet cycles before lock drops
    parameter int DISPLAY_CYCLES = 16     // on-time per line
) (
    input  wire                          sysclk,
    input  wire                          rst,
    input  wire                          ir_tripped, // gate, once per turn
    input  pov_geom_pkg::pattern_mode_e  mode,
    output logic [1:0]                   led,
    output hub75_pkg::hub75_pins_t       hub75
);
    import pov_geom_pkg::*;
    import hub75_pkg::*;

    theta_t     theta;
    logic       locked;
    logic       ir_seen;
    logic       line_push;
    line_pair_t line_data;
    logic       credit_return;

    rotation_tracker #(
        .STALL_CYCLES(STALL_CYCLES)
    ) i_rotation_tracker (
        .sysclk    (sysclk),
        .rst       (rst),
        .ir_tripped(ir_tripped),
        .theta     (theta),
        .locked    (locked),
        .ir_seen   (ir_seen)
    );

    line_renderer i_line_renderer (
        .sysclk       (sysclk),
        .rst          (rst),
        .theta        (theta),
        .locked       (locked),
        .mode         (mode),
        .credit_return(credit_return),
        .line_push    (line_push),
        .line_data    (line_data)
    );

    hub75_output #(
        .DISPLAY_CYCLES(DISPLAY_CYCLES)
    ) i_hub75_output (
        .sysclk       (sysclk),
        .rst          (rst),
        .line_push    (line_push),
        .line_data    (line_data),
        .credit_return(credit_return),
        .hub75        (hub75)
    );

    assign led = {ir_seen, locked}; // led1 blinks with the gate, led0 = locked

endmodule

// File: verif/pov_tb_clk.sv
module pov_tb_clk #(
    parameter int PERIOD_NS = 40
) (
    output logic sysclk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial sysclk = 1'b0;
    always #(PERIOD_NS / 2.0) sysclk = ~sysclk; // free running, 50% duty

endmodule

// File: verif/pov_asserts.sv
module pov_asserts (
    input wire                                sysclk,
    input wire                                rst,
    input hub75_pkg::hub75_pins_t             hub75,
    input wire                                line_push,
    input logic [hub75_pkg::CREDIT_BITS-1:0]  fifo_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import hub75_pkg::*;

    int   assert_fails = 0; // read back by the testbench at the end
    logic clk_q;            // shift clock one cycle back
    int   rise_cnt;         // shift clock rises since the last latch

    always_ff @(posedge sysclk) begin
        if (rst) begin
            clk_q    <= 1'b0;
            rise_cnt <= 0;
        end else begin
            clk_q <= hub75.clk;
            if (hub75.latch) begin
                rise_cnt <= 0;
            end else if (hub75.clk && !clk_q) begin
                rise_cnt <= rise_cnt + 1;
            end
        end
    end

    // panel blanked while the latch strobes, lit again right after
    latch_while_dark: assert property (@(posedge sysclk) disable iff (rst)
        hub75.latch |-> hub75.oe_n ##1 !hub75.oe_n)
        else begin
            $error("latch while oe_n is low, or display did not follow the latch");
            assert_fails++;
        end

    // one full row of columns per latch
    cols_per_latch: assert property (@(posedge sysclk) disable iff (rst)
        hub75.latch |-> (rise_cnt == PANEL_COLS))
        else begin
            $error("latch after %0d shift clock rises", rise_cnt);
            assert_fails++;
        end

    // credits held by the buffer stay within its depth
    credits_bounded: assert property (@(posedge sysclk) disable iff (rst)
        (fifo_count <= LINE_CREDITS) && (!line_push || fifo_count < LINE_CREDITS))
        else begin
            $error("line buffer over its credit limit, count %0d", fifo_count);
            assert_fails++;
        end

endmodule

// File: verif/pov_tb.sv
module pov_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pov_geom_pkg::*;
    import hub75_pkg::*;

    localparam int STALL_CYCLES    = 20000;
    localparam int DISPLAY_CYCLES  = 16;
    localparam int IR_PULSE_CYCLES = 4;
    localparam int SETTLE_CYCLES   = 300;  // render to latch is about 140 cycles
    localparam int QUIET_WINDOW    = 1000;
    localparam int NUM_ROWS        = 5;

    typedef enum logic [1:0] {CHK_NONE, CHK_BLACK, CHK_RING, CHK_SECTOR} check_kind_e;

    typedef struct packed {
        int            period; // ir period in cycles, 0 = pulses stop
        int            revs;
        pattern_mode_e mode;
        logic          lock;   // led[0] at the end of each revolution
        check_kind_e   kind;
        int            jitter; // max +- cycles per period
    } stim_row_t;

    stim_row_t stim [NUM_ROWS] = '{
        '{period: 4096, revs: 1, mode: MODE_RING,   lock: 1'b0, kind: CHK_BLACK,  jitter: 0},
        '{period: 4096, revs: 3, mode: MODE_RING,   lock: 1'b1, kind: CHK_RING,   jitter: 0},
        '{period: 4096, revs: 3, mode: MODE_SECTOR, lock: 1'b1, kind: CHK_SECTOR, jitter: 0},
        '{period: 4096, revs: 4, mode: MODE_SECTOR, lock: 1'b1, kind: CHK_SECTOR, jitter: 16},
        '{period: 0,    revs: 0, mode: MODE_SECTOR, lock: 1'b0, kind: CHK_BLACK,  jitter: 0}
    };

    logic          sysclk;
    logic          rst;
    logic          ir_tripped;
    pattern_mode_e mode;
    logic [1:0]    led;
    hub75_pins_t   hub75;

    int unsigned   cycle = 0;      // rising edges so far
    int unsigned   last_edge = 0;  // cycle of the last ir rise driven
    int            ir_edges = 0;   // ir rises driven so far
    int            cur_period = 4096;
    check_kind_e   check_kind = CHK_NONE;
    int            errors = 0;
    int            timeouts = 0;
    int            lines_checked = 0;
    int            total_lines = 0;
    integer        seed = 98;
    pixel_t        col_upper [PANEL_COLS];
    pixel_t        col_lower [PANEL_COLS];
    int            rise_cnt;
    logic          clk_q;
    scan_addr_t    exp_addr;

    pov_tb_clk i_pov_tb_clk (.sysclk(sysclk));

    pov_display_top #(
        .STALL_CYCLES  (STALL_CYCLES),
        .DISPLAY_CYCLES(DISPLAY_CYCLES)
    ) i_pov_display_top (
        .sysclk    (sysclk),
        .rst       (rst),
        .ir_tripped(ir_tripped),
        .mode      (mode),
        .led       (led),
        .hub75     (hub75)
    );

    bind hub75_output pov_asserts i_pov_asserts (
        .sysclk    (sysclk),
        .rst       (rst),
        .hub75     (hub75),
        .line_push (line_push),
        .fifo_count(fifo_count)
    );

    always @(posedge sysclk) cycle <= cycle + 1;

    task automatic next_cycle();
        @(posedge sysclk);
        #1; // inputs change just after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // compare one latched line pair with the pattern rules
    task automatic check_line(input scan_addr_t addr);
        int     s_line;
        int     s_pred;
        pixel_t exp_up;
        pixel_t exp_lo;
        check_value("hub75.addr", exp_addr, addr); // 0..7 in turn
        if (check_kind != CHK_NONE) begin
            lines_checked++;
            s_line = {col_upper[0].r, col_upper[0].g, col_upper[0].b};
            s_pred = (8 * int'(cycle - last_edge)) / cur_period;
            for (int c = 0; c < PANEL_COLS; c++) begin
                case (check_kind)
                    CHK_RING: begin
                        exp_up = (c == int'(addr)) ? 3'b111 : 3'b000;
                        exp_lo = (c == int'(addr) + SCAN_ADDRS) ? 3'b111 : 3'b000;
                    end
                    CHK_SECTOR: begin
                        exp_up = 3'((s_line + c) % 8); // r is colour bit 2
                        exp_lo = exp_up;
                    end
                    default: begin
                        exp_up = 3'b000;
                        exp_lo = 3'b000;
                    end
                endcase
                check_value($sformatf("hub75.rgb0[%0d]", c), exp_up, col_upper[c]);
                check_value($sformatf("hub75.rgb1[%0d]", c), exp_lo, col_lower[c]);
            end
            // line may lag the angle by up to one sector
            if (check_kind == CHK_SECTOR) begin
                assert (s_line == s_pred % 8 || s_line == (s_pred + 7) % 8) else begin
                    $display("MISMATCH t=%0t sector base exp=%0d or %0d got=%0d",
                             $time, s_pred % 8, (s_pred + 7) % 8, s_line);
                    errors++;
                end
            end
        end
    endtask

    // pin sampler, values seen here are the ones held over the last cycle
    always @(posedge sysclk) begin
        if (rst) begin
            rise_cnt <= 0;
            clk_q    <= 1'b0;
            exp_addr <= '0;
        end else begin
            clk_q <= hub75.clk;
            if (hub75.clk && !clk_q && rise_cnt < PANEL_COLS) begin
                col_upper[rise_cnt] <= hub75.rgb0;
                col_lower[rise_cnt] <= hub75.rgb1;
                rise_cnt            <= rise_cnt + 1;
            end
            if (hub75.latch) begin
                check_line(hub75.addr);
                rise_cnt <= 0;
                exp_addr <= exp_addr + 1'b1;
            end
        end
    end

    task automatic wait_lock_loss();
        while (led[0] === 1'b1 && int'(cycle - last_edge) < STALL_CYCLES + 8) begin
            next_cycle();
        end
        if (led[0] === 1'b1) begin
            $display("timeout: led[0] still high %0d cycles after the last IR pulse",
                     cycle - last_edge);
            timeouts++;
        end
    endtask

    initial begin
        stim_row_t row;
        int        p;
        int        fails;
        rst        = 1'b1;
        ir_tripped = 1'b0;
        mode       = MODE_SECTOR;
        for (int i = 1; i <= 5; i++) begin
            next_cycle();
            check_value("hub75.oe_n", 1, hub75.oe_n); // dark through reset
            check_value("hub75.latch", 0, hub75.latch);
            check_value("hub75.clk", 0, hub75.clk);
            check_value("led[0]", 0, led[0]);
            if (i == 4) rst = 1'b0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            row           = stim[r];
            mode          = row.mode;
            lines_checked = 0;
            if (row.period == 0) begin
                wait_lock_loss();
                repeat (SETTLE_CYCLES) next_cycle();
                check_kind = row.kind;
                repeat (QUIET_WINDOW) next_cycle();
                check_value("led[0]", row.lock, led[0]);
            end else begin
                cur_period = row.period;
                for (int n = 0; n < row.revs; n++) begin
                    p = row.period;
                    if (row.jitter != 0) begin
                        p = p + $random(seed) % (row.jitter + 1);
                    end
                    ir_tripped = 1'b1;
                    last_edge  = cycle;
                    ir_edges++;
                    for (int k = 1; k <= p; k++) begin
                        next_cycle();
                        if (k == IR_PULSE_CYCLES) ir_tripped = 1'b0;
                        if (n == 0 && k == SETTLE_CYCLES) check_kind = row.kind;
                    end
                    check_value("led[0]", row.lock, led[0]);
                    check_value("led[1]", ir_edges % 2, led[1]); // flips once per gate edge
                end
            end
            check_kind = CHK_NONE;
            assert (lines_checked > 0) else begin
                $display("row %0d: no line was latched while checks were armed", r);
                errors++;
            end
            total_lines += lines_checked;
        end
        fails = i_pov_display_top.i_hub75_output.i_pov_asserts.assert_fails;
        $display("lines checked %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 total_lines, errors, timeouts, fails);
        if (errors == 0 && timeouts == 0 && fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/pov_geom_pkg.sv
rtl/hub75_pkg.sv
rtl/rotation_tracker.sv
rtl/line_renderer.sv
rtl/hub75_output.sv
rtl/pov_display_top.sv
verif/pov_tb_clk.sv
verif/pov_asserts.sv
verif/pov_tb.sv

// File: Bender.yml
package:
  name: pov_display

sources:
  # packages come first, every module imports them
  - rtl/pov_geom_pkg.sv
  - rtl/hub75_pkg.sv
  - rtl/rotation_tracker.sv
  - rtl/line_renderer.sv
  - rtl/hub75_output.sv
  - rtl/pov_display_top.sv
  # simulation only, top module pov_tb
  - target: test
    files:
      - verif/pov_tb_clk.sv
      - verif/pov_asserts.sv
      - verif/pov_tb.sv
